/* include/muldiv_macros.svh */
//////////////////////////////
// Width settings for the multiply and divide unit
// Include before the package and in every RTL file that needs them
//////////////////////////////

`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// Data width of the integer datapath
// RV64 by default; the W forms assume 64
`define XLEN 64

// One restoring step per quotient bit
`define DIV_ITERS `XLEN

`endif

/* source/muldivPkg.sv */
//////////////////////////////
// Shared types of the multiply and divide unit
// Imported by the RTL files and the testbench
//////////////////////////////

`include "muldiv_macros.svh"

package muldivPkg;

   // Operation codes in funct3 order of the M extension
   typedef enum logic [2:0] {
      OP_MUL    = 3'b000,
      OP_MULH   = 3'b001,
      OP_MULHSU = 3'b010,
      OP_MULHU  = 3'b011,
      OP_DIV    = 3'b100,
      OP_DIVU   = 3'b101,
      OP_REM    = 3'b110,
      OP_REMU   = 3'b111
   } mulDivOpT;

   // Iterative divider FSM
   typedef enum logic [1:0] {
      DIV_IDLE = 2'b00,
      DIV_BUSY = 2'b01,
      DIV_DONE = 2'b10
   } divStateT;

   // Register-width word
   typedef logic [`XLEN-1:0] wordT;

   // Full product width
   typedef logic [2*`XLEN-1:0] dwordT;

endpackage

/* source/divIf.sv */
//////////////////////////////
// Request and result bundle of the iterative divider
// ctrl side sits in the unit top, unit side in the divider
//////////////////////////////

interface divIf;

   import muldivPkg::*;

   // Request, held by the issuing side until done
   logic start;
   wordT dividend;
   wordT divisor;
   logic isSigned;

   // Status and results
   logic busy;
   logic done;
   wordT quot;
   wordT rem;

   // Issuing side
   modport ctrl (
      output start, dividend, divisor, isSigned,
      input  busy, done, quot, rem
   );

   // Divider side
   modport unit (
      input  start, dividend, divisor, isSigned,
      output busy, done, quot, rem
   );

endinterface

/* source/mulUnit.sv */
//////////////////////////////
// Combinational multiplier for MUL, MULH, MULHSU and MULHU
// Gives the full double-width product in the execute cycle
//////////////////////////////

`include "muldiv_macros.svh"

module mulUnit (
   input  muldivPkg::wordT  a,
   input  muldivPkg::wordT  b,
   input  logic             aSigned,
   input  logic             bSigned,
   output muldivPkg::dwordT prod
);

   // Operands widened by one bit so one signed multiply covers all modes
   logic signed [`XLEN:0]     aExt;
   logic signed [`XLEN:0]     bExt;

   // Product of the widened operands
   logic signed [2*`XLEN+1:0] fullProd;

   // Sign bit copied only when that operand counts as signed
   // MULHSU ends up as signed a times zero-extended b
   assign aExt = {aSigned & a[`XLEN-1], a};
   assign bExt = {bSigned & b[`XLEN-1], b};

   // Widen before multiplying so no high bits are lost
   always_comb begin
      fullProd = (2*`XLEN+2)'(aExt) * (2*`XLEN+2)'(bExt);
   end

   // Top two bits are only sign copies, drop them
   assign prod = fullProd[2*`XLEN-1:0];

endmodule

/* source/divUnit.sv */
//////////////////////////////
// Iterative radix-2 restoring divider, one quotient bit per cycle
// Start in idle, busy for DIV_ITERS cycles, then done for one cycle
//////////////////////////////

`include "muldiv_macros.svh"

module divUnit (
   input logic clk,
   input logic rstN,
   divIf.unit  div
);

   import muldivPkg::*;

   localparam int CntW = $clog2(`DIV_ITERS);

   // Control state
   divStateT        state;
   divStateT        stateNext;
   logic [CntW-1:0] iterCnt;
   logic            accept;
   logic            lastIter;

   // Working registers
   // quotR starts as |dividend| and fills with quotient bits from the right
   wordT            quotR;
   wordT            remR;
   wordT            divisorR;

   // Fix-up information captured at start
   logic            negQuot;
   logic            negRem;
   logic            divZero;
   logic            overflow;

   // One restoring step
   logic [`XLEN:0]  remShift;
   logic [`XLEN:0]  diff;

   // Operand magnitudes
   wordT            absA;
   wordT            absB;
   logic            signA;
   logic            signB;

   // Signed results
   wordT            quotFix;
   wordT            remFix;

   //////////////////////////////
   // Start and operand capture
   //////////////////////////////

   // Only an idle divider takes a new request
   assign accept = (state == DIV_IDLE) & div.start;

   assign signA = div.isSigned & div.dividend[`XLEN-1];
   assign signB = div.isSigned & div.divisor[`XLEN-1];

   // Most negative number stays as is and reads as 2^(XLEN-1) unsigned
   assign absA = signA ? -div.dividend : div.dividend;
   assign absB = signB ? -div.divisor : div.divisor;

   //////////////////////////////
   // FSM
   //////////////////////////////

   assign lastIter = (iterCnt == CntW'(`DIV_ITERS - 1));

   always_comb begin
      stateNext = state;
      case (state)
         DIV_IDLE: if (accept) stateNext = DIV_BUSY;
         DIV_BUSY: if (lastIter) stateNext = DIV_DONE;
         // Done lasts exactly one cycle
         DIV_DONE: stateNext = DIV_IDLE;
         default:  stateNext = DIV_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state   <= DIV_IDLE;
         iterCnt <= '0;
      end else begin
         state <= stateNext;
         if (accept)
            iterCnt <= '0;
         else if (state == DIV_BUSY)
            iterCnt <= iterCnt + 1'b1;
      end
   end

   //////////////////////////////
   // Shift-subtract datapath
   //////////////////////////////

   // Shift the next dividend bit into the partial remainder
   assign remShift = {remR, quotR[`XLEN-1]};
   assign diff     = remShift - {1'b0, divisorR};

   // Enabled on capture and on every busy cycle, held otherwise
   always_ff @(posedge clk) begin
      if (accept) begin
         quotR    <= absA;
         remR     <= '0;
         divisorR <= absB;
         // Quotient sign follows the operand signs, remainder takes the dividend's
         negQuot  <= signA ^ signB;
         negRem   <= signA;
         divZero  <= (div.divisor == '0);
         overflow <= div.isSigned & (div.dividend == {1'b1, {(`XLEN-1){1'b0}}})
                     & (div.divisor == '1);
      end else if (state == DIV_BUSY) begin
         if (!diff[`XLEN]) begin
            // Subtract fits, quotient bit is one
            remR  <= diff[`XLEN-1:0];
            quotR <= {quotR[`XLEN-2:0], 1'b1};
         end else begin
            // Restore, quotient bit is zero
            remR  <= remShift[`XLEN-1:0];
            quotR <= {quotR[`XLEN-2:0], 1'b0};
         end
      end
   end

   //////////////////////////////
   // Result fix-up
   //////////////////////////////

   always_comb begin
      quotFix = negQuot ? -quotR : quotR;
      remFix  = negRem ? -remR : remR;
      if (divZero) begin
         // Quotient all ones, remainder the dividend
         // Remainder already comes out as |dividend| with the dividend's sign
         quotFix = '1;
      end else if (overflow) begin
         // Most negative / -1 returns the dividend with no remainder
         quotFix = {1'b1, {(`XLEN-1){1'b0}}};
         remFix  = '0;
      end
   end

   // Status straight from the state register
   assign div.busy = (state == DIV_BUSY);
   assign div.done = (state == DIV_DONE);

   // Valid while done is high
   assign div.quot = quotFix;
   assign div.rem  = remFix;

endmodule

/* source/muldiv.sv */
//////////////////////////////
// M extension unit of the execute stage, top level
// Multiply in the execute cycle, divide on the iterative divider
// Result goes through the M and W pipeline registers
//////////////////////////////

`include "muldiv_macros.svh"

module muldiv (
   input  logic                 clk,
   input  logic                 rstN,
   input  muldivPkg::wordT      srcA,
   input  muldivPkg::wordT      srcB,
   input  muldivPkg::mulDivOpT  op,
   input  logic                 mulDiv,
   input  logic                 w64,
   input  logic                 stallM,
   input  logic                 stallW,
   input  logic                 flushM,
   input  logic                 flushW,
   output muldivPkg::wordT      mulDivResultW,
   output logic                 divBusy,
   output logic                 divDone
);

   import muldivPkg::*;

   // Decoded operation
   logic  isDivOp;
   logic  divSigned;
   logic  mulASigned;
   logic  mulBSigned;

   // Prepared operands
   wordT  opA;
   wordT  opB;

   // Execute results
   dwordT prodE;
   wordT  prelimE;
   wordT  resultE;

   // Memory-stage register
   wordT  resultM;

   divIf  divBus ();

   //////////////////////////////
   // Decode
   //////////////////////////////

   assign isDivOp   = (op == OP_DIV) | (op == OP_DIVU) | (op == OP_REM) | (op == OP_REMU);
   assign divSigned = (op == OP_DIV) | (op == OP_REM);

   // MULH treats both as signed, MULHSU only the first
   assign mulASigned = (op == OP_MULH) | (op == OP_MULHSU);
   assign mulBSigned = (op == OP_MULH);

   // W forms work on the low word
   // Sign-extend for DIVW and REMW, zero-extend for the unsigned ones
   // MULW only keeps the low 32 product bits, so the extension does not matter there
   assign opA = w64 ? {{(`XLEN-32){divSigned & srcA[31]}}, srcA[31:0]} : srcA;
   assign opB = w64 ? {{(`XLEN-32){divSigned & srcB[31]}}, srcB[31:0]} : srcB;

   //////////////////////////////
   // Multiplier and divider
   //////////////////////////////

   mulUnit mulUnit0 (
      .a       (opA),
      .b       (opB),
      .aSigned (mulASigned),
      .bSigned (mulBSigned),
      .prod    (prodE)
   );

   // Request a divide until the divider reports done
   // Done masks the request so the held instruction does not start again
   assign divBus.start    = mulDiv & isDivOp & ~divBus.done;
   assign divBus.dividend = opA;
   assign divBus.divisor  = opB;
   assign divBus.isSigned = divSigned;

   divUnit divUnit0 (
      .clk  (clk),
      .rstN (rstN),
      .div  (divBus)
   );

   assign divBusy = divBus.busy;
   assign divDone = divBus.done;

   //////////////////////////////
   // Result selection
   //////////////////////////////

   always_comb begin
      prelimE = prodE[`XLEN-1:0];
      case (op)
         OP_MUL:    prelimE = prodE[`XLEN-1:0];
         OP_MULH:   prelimE = prodE[2*`XLEN-1:`XLEN];
         OP_MULHSU: prelimE = prodE[2*`XLEN-1:`XLEN];
         OP_MULHU:  prelimE = prodE[2*`XLEN-1:`XLEN];
         OP_DIV:    prelimE = divBus.quot;
         OP_DIVU:   prelimE = divBus.quot;
         OP_REM:    prelimE = divBus.rem;
         OP_REMU:   prelimE = divBus.rem;
         default:   prelimE = prodE[`XLEN-1:0];
      endcase
   end

   // W forms return the sign-extended low word
   assign resultE = w64 ? {{(`XLEN-32){prelimE[31]}}, prelimE[31:0]} : prelimE;

   //////////////////////////////
   // M and W pipeline registers
   //////////////////////////////

   // Flush beats stall, a stall holds the content
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         resultM       <= '0;
         mulDivResultW <= '0;
      end else begin
         if (flushM)
            resultM <= '0;
         else if (!stallM)
            resultM <= resultE;

         if (flushW)
            mulDivResultW <= '0;
         else if (!stallW)
            mulDivResultW <= resultM;
      end
   end

endmodule

/* sim/muldivTb.sv */
//////////////////////////////
// Self-checking random testbench of the multiply and divide unit
// A model of the E, M and W stages is checked on every falling edge
//////////////////////////////

`include "muldiv_macros.svh"

module muldivTb;

   import muldivPkg::*;

   localparam wordT MinNeg      = {1'b1, {(`XLEN-1){1'b0}}};
   localparam wordT WMinNeg     = {{(`XLEN-32){1'b1}}, 32'h8000_0000};
   localparam int   NumMul      = 200;
   localparam int   NumDiv      = 60;
   localparam int   DoneTimeout = `DIV_ITERS + 20;

   // DUT inputs
   logic     clk;
   logic     rstN;
   wordT     srcA;
   wordT     srcB;
   mulDivOpT op;
   logic     mulDiv;
   logic     w64;
   logic     stallM;
   logic     stallW;
   logic     flushM;
   logic     flushW;

   // DUT outputs
   wordT     mulDivResultW;
   logic     divBusy;
   logic     divDone;

   // Model of the execute result and the two pipeline registers
   wordT     expE;
   logic     validE;
   wordT     expM = '0;
   logic     validM = 1'b1;
   wordT     expW = '0;
   logic     validW = 1'b1;

   muldiv dut0 (
      .clk           (clk),
      .rstN          (rstN),
      .srcA          (srcA),
      .srcB          (srcB),
      .op            (op),
      .mulDiv        (mulDiv),
      .w64           (w64),
      .stallM        (stallM),
      .stallW        (stallW),
      .flushM        (flushM),
      .flushW        (flushW),
      .mulDivResultW (mulDivResultW),
      .divBusy       (divBusy),
      .divDone       (divDone)
   );

   always #5 clk = ~clk;

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic logic isDivide(input mulDivOpT o);
      return (o == OP_DIV) || (o == OP_DIVU) || (o == OP_REM) || (o == OP_REMU);
   endfunction

   function automatic wordT refResult(input mulDivOpT o, input wordT a, input wordT b,
                                      input logic w);
      logic                    sgn;
      wordT                    x;
      wordT                    y;
      logic signed [`XLEN-1:0] sx;
      logic signed [`XLEN-1:0] sy;
      logic [2*`XLEN-1:0]      prodU;
      wordT                    hi;
      wordT                    q;
      wordT                    rm;
      wordT                    r;
      sgn = (o == OP_DIV) || (o == OP_REM);
      x = a;
      y = b;
      if (w) begin
         // W forms use the low words extended by the divide's signedness
         x = {{(`XLEN-32){sgn & a[31]}}, a[31:0]};
         y = {{(`XLEN-32){sgn & b[31]}}, b[31:0]};
      end
      sx = x;
      sy = y;
      // Unsigned product with the signed high halves corrected from it
      prodU = {{`XLEN{1'b0}}, x} * {{`XLEN{1'b0}}, y};
      hi = prodU[2*`XLEN-1:`XLEN];
      // Division with the spec's corner rules
      if (y == '0) begin
         q  = '1;
         rm = x;
      end else if (sgn && x == MinNeg && y == '1) begin
         q  = x;
         rm = '0;
      end else if (sgn) begin
         q  = sx / sy;
         rm = sx % sy;
      end else begin
         q  = x / y;
         rm = x % y;
      end
      case (o)
         OP_MUL:          r = prodU[`XLEN-1:0];
         OP_MULH:         r = hi - (x[`XLEN-1] ? y : '0) - (y[`XLEN-1] ? x : '0);
         OP_MULHSU:       r = hi - (x[`XLEN-1] ? y : '0);
         OP_MULHU:        r = hi;
         OP_DIV, OP_DIVU: r = q;
         default:         r = rm;
      endcase
      if (w)
         r = {{(`XLEN-32){r[31]}}, r[31:0]};
      return r;
   endfunction

   // A divide result only exists in the divDone cycle
   always @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         expM   = '0;
         validM = 1'b1;
         expW   = '0;
         validW = 1'b1;
      end else begin
         expE   = refResult(op, srcA, srcB, w64);
         validE = !isDivide(op) || divDone;
         if (flushW) begin
            expW   = '0;
            validW = 1'b1;
         end else if (!stallW) begin
            expW   = expM;
            validW = validM;
         end
         if (flushM) begin
            expM   = '0;
            validM = 1'b1;
         end else if (!stallM) begin
            expM   = expE;
            validM = validE;
         end
      end
   end

   always @(negedge clk) begin
      if (validW)
         checkValue("mulDivResultW", expW, mulDivResultW);
   end

   //////////////////////////////
   // Checks and stimulus
   //////////////////////////////

   task automatic checkValue(input string name, input wordT expected, input wordT actual);
      if (actual !== expected) begin
         $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Corner-weighted operand
   function automatic wordT randOperand();
      wordT v;
      v = {$urandom, $urandom};
      case ($urandom_range(0, 9))
         0: v = '0;
         1: v = '1;
         2: v = MinNeg;
         3: v = WMinNeg;
         4: v = wordT'(1);
         5: v = v >> $urandom_range(0, `XLEN-1);
         default: ;
      endcase
      return v;
   endfunction

   task automatic driveOp(input mulDivOpT o, input wordT a, input wordT b, input logic w);
      @(posedge clk);
      op     <= o;
      srcA   <= a;
      srcB   <= b;
      w64    <= w;
      mulDiv <= 1'b1;
   endtask

   task automatic runMultiplies(input int n);
      repeat (n)
         driveOp(mulDivOpT'(3'($urandom_range(0, 3))), randOperand(), randOperand(),
                 1'($urandom_range(0, 1)));
   endtask

   // Request held until done
   // Done must come DIV_ITERS+1 edges after the request
   task automatic runDivide(input mulDivOpT o, input wordT a, input wordT b, input logic w);
      int   edges;
      logic seen;
      driveOp(o, a, b, w);
      edges = 0;
      seen  = 1'b0;
      while (!seen) begin
         @(posedge clk);
         edges++;
         @(negedge clk);
         if (divDone) begin
            seen = 1'b1;
         end else begin
            checkValue("divBusy", wordT'(1), wordT'(divBusy));
            if (edges > DoneTimeout) begin
               $display("Divider never finished within %0d cycles of the request", DoneTimeout);
               $display("SOME TESTS FAILED");
               $fatal(1, "divider timeout");
            end
         end
      end
      checkValue("divDone edges", wordT'(`DIV_ITERS + 1), wordT'(edges));
      checkValue("divBusy", '0, wordT'(divBusy));
   endtask

   task automatic runCorners();
      wordT a;
      wordT b;
      for (int w = 0; w < 2; w++) begin
         for (int i = 4; i < 8; i++) begin
            for (int k = 0; k < 6; k++) begin
               a = '1;
               b = '1;
               case (k)
                  0: begin
                     a = randOperand();
                     b = '0;
                  end
                  1: a = MinNeg;
                  2: a = WMinNeg;
                  3: begin
                     a = '0;
                     b = randOperand();
                  end
                  5: b = '0;
                  default: ;
               endcase
               runDivide(mulDivOpT'(3'(i)), a, b, 1'(w));
            end
         end
      end
   endtask

   task automatic checkStallFlush();
      wordT held;
      wordT a;
      wordT b;
      driveOp(OP_MUL, randOperand(), randOperand(), 1'b0);
      driveOp(OP_MULHU, randOperand(), randOperand(), 1'b0);
      // W holds while new products arrive
      @(posedge clk);
      stallW <= 1'b1;
      @(negedge clk);
      held = mulDivResultW;
      // Odd operands keep every new product odd and nonzero
      repeat (4) begin
         driveOp(OP_MUL, randOperand() | wordT'(1), randOperand() | wordT'(1), 1'b0);
         @(negedge clk);
         checkValue("mulDivResultW", held, mulDivResultW);
      end
      // M holds and W settles on the held M value
      @(posedge clk);
      stallW <= 1'b0;
      stallM <= 1'b1;
      // Both operands in [2^62, 2^63) so every high half is nonzero
      repeat (3) begin
         a = randOperand();
         b = randOperand();
         a[`XLEN-1:`XLEN-2] = 2'b01;
         b[`XLEN-1:`XLEN-2] = 2'b01;
         driveOp(OP_MULH, a, b, 1'b0);
      end
      // Flush beats the stall in M
      // The zero reaches W one edge later
      @(posedge clk);
      flushM <= 1'b1;
      @(posedge clk);
      flushM <= 1'b0;
      stallM <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      checkValue("mulDivResultW", '0, mulDivResultW);
      @(posedge clk);
      flushW <= 1'b1;
      @(posedge clk);
      flushW <= 1'b0;
      @(negedge clk);
      checkValue("mulDivResultW", '0, mulDivResultW);
   endtask

   // With the request gone no divide may start
   task automatic checkIdle();
      @(posedge clk);
      mulDiv <= 1'b0;
      op     <= OP_DIV;
      repeat (6) begin
         @(negedge clk);
         checkValue("divBusy", '0, wordT'(divBusy));
         checkValue("divDone", '0, wordT'(divDone));
      end
   endtask

   initial begin
      void'($urandom(32'h79d304ac));
      clk    = 1'b0;
      rstN   = 1'b0;
      srcA   = '0;
      srcB   = '0;
      op     = OP_MUL;
      mulDiv = 1'b0;
      w64    = 1'b0;
      stallM = 1'b0;
      stallW = 1'b0;
      flushM = 1'b0;
      flushW = 1'b0;

      repeat (3) @(posedge clk);
      @(negedge clk);
      checkValue("divBusy", '0, wordT'(divBusy));
      checkValue("divDone", '0, wordT'(divDone));
      checkValue("mulDivResultW", '0, mulDivResultW);
      @(posedge clk);
      rstN <= 1'b1;

      runMultiplies(NumMul);
      checkStallFlush();
      runCorners();
      repeat (NumDiv)
         runDivide(mulDivOpT'(3'($urandom_range(4, 7))), randOperand(), randOperand(),
                   1'($urandom_range(0, 1)));
      runMultiplies(20);
      checkIdle();

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
source/muldivPkg.sv
source/divIf.sv
source/mulUnit.sv
source/divUnit.sv
source/muldiv.sv
sim/muldivTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f flist.f --top-module muldivTb -o muldivSim; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/muldivSim; then
   echo "Simulation returned a failing status"
   exit 1
fi

exit 0
